// ==== verilog/vec_pkg.sv ====
// Vector data shapes: lane width, SEW codes, lane word union, destination tag width
`default_nettype none

package vec_pkg;

    localparam int ELEM_W = 64;             // One functional-unit lane
    localparam int TAG_W  = 5;

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_e;

    // Same 64-bit lane word seen as elements of each SEW
    typedef union packed {
        logic [7:0][7:0]  b;
        logic [3:0][15:0] h;
        logic [1:0][31:0] w;
        logic [63:0]      d;
    } elem_u;

endpackage

`default_nettype wire

// ==== verilog/op_pkg.sv ====
// Operation codes, multiply class test and per-class latencies
`default_nettype none

package op_pkg;

    typedef enum logic [3:0] {
        OP_ADD    = 4'd0,
        OP_SUB    = 4'd1,
        OP_AND    = 4'd2,
        OP_OR     = 4'd3,
        OP_XOR    = 4'd4,
        OP_MUL    = 4'd5,
        OP_MULHU  = 4'd6,
        OP_MV_X_S = 4'd7
    } vop_e;

    localparam int ALU_LAT        = 1;
    localparam int MUL_LAT_NARROW = 2;  // SEW 8, 16, 32
    localparam int MUL_LAT_WIDE   = 3;  // SEW 64

    function automatic logic is_mul(input vop_e op);
        return (op == OP_MUL) || (op == OP_MULHU);
    endfunction

endpackage

`default_nettype wire

// ==== verilog/operand_bcast.sv ====
// First operand select: vector source or scalar replicated per SEW
`timescale 1ns/100ps
`default_nettype none

module operand_bcast #(
    parameter int VLEN = 128
) (
    input  vec_pkg::sew_e    sew_i,
    input  logic             scalar_i,
    input  logic [63:0]      rs1_i,
    input  logic [VLEN-1:0]  vs1_i,
    output logic [VLEN-1:0]  op_a_o
);

    localparam int LANES = VLEN / vec_pkg::ELEM_W;

    logic [63:0] rs1_rep;   // One lane worth of replicated scalar

    always_comb begin
        case (sew_i)
            vec_pkg::SEW_8:  rs1_rep = {8{rs1_i[7:0]}};
            vec_pkg::SEW_16: rs1_rep = {4{rs1_i[15:0]}};
            vec_pkg::SEW_32: rs1_rep = {2{rs1_i[31:0]}};
            default:         rs1_rep = rs1_i;
        endcase
    end

    assign op_a_o = scalar_i ? {LANES{rs1_rep}} : vs1_i;

endmodule

`default_nettype wire

// ==== verilog/lane_alu.sv ====
// Single-cycle element-wise add, sub and logic ops, element 0 scalar extract
`timescale 1ns/100ps
`default_nettype none

module lane_alu #(
    parameter int VLEN = 128
) (
    input  logic             valid_i,
    input  op_pkg::vop_e     op_i,
    input  vec_pkg::sew_e    sew_i,
    input  logic [VLEN-1:0]  op_a_i,
    input  logic [VLEN-1:0]  vs2_i,
    output logic             alu_valid_o,
    output logic [VLEN-1:0]  alu_vd_o,
    output logic             alu_rd_valid_o,
    output logic [63:0]      alu_rd_o
);

    localparam int W     = vec_pkg::ELEM_W;
    localparam int LANES = VLEN / W;

    vec_pkg::elem_u v0;

    // x is the vs2 element, y the first operand
    function automatic logic [63:0] elem_op(input op_pkg::vop_e op,
                                            input logic [63:0] x,
                                            input logic [63:0] y);
        case (op)
            op_pkg::OP_ADD: elem_op = x + y;
            op_pkg::OP_SUB: elem_op = x - y;
            op_pkg::OP_AND: elem_op = x & y;
            op_pkg::OP_OR:  elem_op = x | y;
            default:        elem_op = x ^ y;
        endcase
    endfunction

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        vec_pkg::elem_u ua, ub, ur;

        assign ua = op_a_i[l*W +: W];
        assign ub = vs2_i[l*W +: W];

        // Truncation keeps carries inside each element
        always_comb begin
            ur = '0;
            case (sew_i)
                vec_pkg::SEW_8: begin
                    for (int e = 0; e < 8; e++) begin
                        ur.b[e] = 8'(elem_op(op_i, 64'(ub.b[e]), 64'(ua.b[e])));
                    end
                end
                vec_pkg::SEW_16: begin
                    for (int e = 0; e < 4; e++) begin
                        ur.h[e] = 16'(elem_op(op_i, 64'(ub.h[e]), 64'(ua.h[e])));
                    end
                end
                vec_pkg::SEW_32: begin
                    for (int e = 0; e < 2; e++) begin
                        ur.w[e] = 32'(elem_op(op_i, 64'(ub.w[e]), 64'(ua.w[e])));
                    end
                end
                default: ur.d = elem_op(op_i, ub.d, ua.d);
            endcase
        end

        assign alu_vd_o[l*W +: W] = ur;
    end

    assign v0 = vs2_i[W-1:0];

    always_comb begin
        case (sew_i)
            vec_pkg::SEW_8:  alu_rd_o = {{56{v0.b[0][7]}}, v0.b[0]};
            vec_pkg::SEW_16: alu_rd_o = {{48{v0.h[0][15]}}, v0.h[0]};
            vec_pkg::SEW_32: alu_rd_o = {{32{v0.w[0][31]}}, v0.w[0]};
            default:         alu_rd_o = v0.d;
        endcase
    end

    assign alu_valid_o    = valid_i && !op_pkg::is_mul(op_i) && (op_i != op_pkg::OP_MV_X_S);
    assign alu_rd_valid_o = valid_i && (op_i == op_pkg::OP_MV_X_S);

endmodule

`default_nettype wire

// ==== verilog/mul_pipe.sv ====
// Multiply lanes: product register, 64-bit partial product sum, payload per stage
`timescale 1ns/100ps
`default_nettype none

module mul_pipe #(
    parameter  int VLEN = 128,
    localparam int VL_W = $clog2(VLEN/8) + 1
) (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      valid_i,
    input  op_pkg::vop_e              op_i,
    input  vec_pkg::sew_e             sew_i,
    input  logic [vec_pkg::TAG_W-1:0] tag_i,
    input  logic [VLEN-1:0]           op_a_i,
    input  logic [VLEN-1:0]           vs2_i,
    input  logic [VLEN-1:0]           old_vd_i,
    input  logic [VLEN/8-1:0]         vm_i,
    input  logic                      use_mask_i,
    input  logic [VL_W-1:0]           vl_i,
    output logic                      mul_valid_o,
    output logic [VLEN-1:0]           mul_vd_o,
    output logic [vec_pkg::TAG_W-1:0] mul_tag_o,
    output vec_pkg::sew_e             mul_sew_o,
    output logic [VLEN-1:0]           mul_old_vd_o,
    output logic [VLEN/8-1:0]         mul_vm_o,
    output logic                      mul_use_mask_o,
    output logic [VL_W-1:0]           mul_vl_o
);

    localparam int W     = vec_pkg::ELEM_W;
    localparam int LANES = VLEN / W;
    localparam int PAY_W = 1 + vec_pkg::TAG_W + VLEN + VLEN/8 + 1 + VL_W;

    logic             s1_valid;
    logic             s2_valid;
    vec_pkg::sew_e    s1_sew;
    logic [PAY_W-1:0] s1_pay;   // {high half, tag, old vd, mask, use mask, vl}
    logic [PAY_W-1:0] s2_pay;
    logic             out_hi;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= valid_i && op_pkg::is_mul(op_i);
            s2_valid <= s1_valid && (s1_sew == vec_pkg::SEW_64);
        end
    end

    always_ff @(posedge clk_i) begin
        s1_sew <= sew_i;
        s1_pay <= {op_i == op_pkg::OP_MULHU, tag_i, old_vd_i, vm_i, use_mask_i, vl_i};
        s2_pay <= s1_pay;
    end

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        vec_pkg::elem_u ua, ub, res;
        logic [255:0]   pp_d;       // Full narrow products or four 32x32 partials
        logic [255:0]   pp_q;
        logic [127:0]   wide_d;
        logic [127:0]   wide_q;

        assign ua = op_a_i[l*W +: W];
        assign ub = vs2_i[l*W +: W];

        always_comb begin
            pp_d = '0;
            case (sew_i)
                vec_pkg::SEW_8:  for (int e = 0; e < 8; e++) pp_d[e*16 +: 16] = ua.b[e] * ub.b[e];
                vec_pkg::SEW_16: for (int e = 0; e < 4; e++) pp_d[e*32 +: 32] = ua.h[e] * ub.h[e];
                vec_pkg::SEW_32: for (int e = 0; e < 2; e++) pp_d[e*64 +: 64] = ua.w[e] * ub.w[e];
                default: begin
                    pp_d[0   +: 64] = ua.w[0] * ub.w[0];
                    pp_d[64  +: 64] = ua.w[0] * ub.w[1];
                    pp_d[128 +: 64] = ua.w[1] * ub.w[0];
                    pp_d[192 +: 64] = ua.w[1] * ub.w[1];
                end
            endcase
        end

        assign wide_d = {64'b0, pp_q[63:0]} + {32'b0, pp_q[127:64], 32'b0}
                      + {32'b0, pp_q[191:128], 32'b0} + {pp_q[255:192], 64'b0};

        always_ff @(posedge clk_i) begin
            pp_q   <= pp_d;
            wide_q <= wide_d;
        end

        always_comb begin
            res = '0;
            if (s2_valid) begin
                res.d = out_hi ? wide_q[127:64] : wide_q[63:0];
            end else begin
                case (s1_sew)
                    vec_pkg::SEW_8:  for (int e = 0; e < 8; e++) res.b[e] = pp_q[e*16 + 8*out_hi +: 8];
                    vec_pkg::SEW_16: for (int e = 0; e < 4; e++) res.h[e] = pp_q[e*32 + 16*out_hi +: 16];
                    default:         for (int e = 0; e < 2; e++) res.w[e] = pp_q[e*64 + 32*out_hi +: 32];
                endcase
            end
        end

        assign mul_vd_o[l*W +: W] = res;
    end

    // Stage two only ever holds SEW 64 work
    assign mul_valid_o = s2_valid || (s1_valid && (s1_sew != vec_pkg::SEW_64));
    assign mul_sew_o   = s2_valid ? vec_pkg::SEW_64 : s1_sew;
    assign {out_hi, mul_tag_o, mul_old_vd_o, mul_vm_o, mul_use_mask_o, mul_vl_o} =
        s2_valid ? s2_pay : s1_pay;

endmodule

`default_nettype wire

// ==== verilog/result_stage.sv ====
// Completion select, mask and tail fill per element, output registers
`timescale 1ns/100ps
`default_nettype none

module result_stage #(
    parameter  int VLEN = 128,
    localparam int VL_W = $clog2(VLEN/8) + 1
) (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      alu_valid_i,
    input  logic [VLEN-1:0]           alu_vd_i,
    input  logic                      alu_rd_valid_i,
    input  logic [63:0]               alu_rd_i,
    input  logic                      mul_valid_i,
    input  logic [VLEN-1:0]           mul_vd_i,
    input  logic [vec_pkg::TAG_W-1:0] mul_tag_i,
    input  vec_pkg::sew_e             mul_sew_i,
    input  logic [VLEN-1:0]           mul_old_vd_i,
    input  logic [VLEN/8-1:0]         mul_vm_i,
    input  logic                      mul_use_mask_i,
    input  logic [VL_W-1:0]           mul_vl_i,
    input  logic [vec_pkg::TAG_W-1:0] tag_i,
    input  vec_pkg::sew_e             sew_i,
    input  logic [VLEN-1:0]           old_vd_i,
    input  logic [VLEN/8-1:0]         vm_i,
    input  logic                      use_mask_i,
    input  logic [VL_W-1:0]           vl_i,
    output logic                      vd_valid_o,
    output logic [VLEN-1:0]           vd_o,
    output logic                      rd_valid_o,
    output logic [63:0]               rd_o,
    output logic [vec_pkg::TAG_W-1:0] tag_o
);

    localparam int W     = vec_pkg::ELEM_W;
    localparam int LANES = VLEN / W;

    logic [VLEN-1:0]           sel_vd;
    logic [VLEN-1:0]           sel_old;
    logic [VLEN/8-1:0]         sel_vm;
    logic                      sel_use_mask;
    logic [VL_W-1:0]           sel_vl;
    logic [vec_pkg::TAG_W-1:0] sel_tag;
    vec_pkg::sew_e             sel_sew;
    logic [VLEN-1:0]           vd_fill;

    // At most one path completes per cycle
    assign sel_vd       = mul_valid_i ? mul_vd_i       : alu_vd_i;
    assign sel_old      = mul_valid_i ? mul_old_vd_i   : old_vd_i;
    assign sel_vm       = mul_valid_i ? mul_vm_i       : vm_i;
    assign sel_use_mask = mul_valid_i ? mul_use_mask_i : use_mask_i;
    assign sel_vl       = mul_valid_i ? mul_vl_i       : vl_i;
    assign sel_tag      = mul_valid_i ? mul_tag_i      : tag_i;
    assign sel_sew      = mul_valid_i ? mul_sew_i      : sew_i;

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        vec_pkg::elem_u r, o, f;

        assign r = sel_vd[l*W +: W];
        assign o = sel_old[l*W +: W];

        // Element index is lane * elements per lane + e
        always_comb begin
            f = r;
            case (sel_sew)
                vec_pkg::SEW_8: begin
                    for (int e = 0; e < 8; e++) begin
                        if (l*8 + e >= sel_vl) f.b[e] = '1;
                        else if (sel_use_mask && !sel_vm[l*8 + e]) f.b[e] = o.b[e];
                    end
                end
                vec_pkg::SEW_16: begin
                    for (int e = 0; e < 4; e++) begin
                        if (l*4 + e >= sel_vl) f.h[e] = '1;
                        else if (sel_use_mask && !sel_vm[l*4 + e]) f.h[e] = o.h[e];
                    end
                end
                vec_pkg::SEW_32: begin
                    for (int e = 0; e < 2; e++) begin
                        if (l*2 + e >= sel_vl) f.w[e] = '1;
                        else if (sel_use_mask && !sel_vm[l*2 + e]) f.w[e] = o.w[e];
                    end
                end
                default: begin
                    if (l >= sel_vl) f.d = '1;
                    else if (sel_use_mask && !sel_vm[l]) f.d = o.d;
                end
            endcase
        end

        assign vd_fill[l*W +: W] = f;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            vd_valid_o <= 1'b0;
            rd_valid_o <= 1'b0;
        end else begin
            vd_valid_o <= alu_valid_i || mul_valid_i;
            rd_valid_o <= alu_rd_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        vd_o  <= vd_fill;
        rd_o  <= alu_rd_i;      // Scalar extract bypasses mask and tail
        tag_o <= sel_tag;
    end

endmodule

`default_nettype wire

// ==== verilog/simd_exec_unit.sv ====
// SIMD execute stage top: operand broadcast, lane ALU, multiply pipe, result stage
`timescale 1ns/100ps
`default_nettype none

module simd_exec_unit #(
    parameter  int VLEN = 128,
    localparam int VL_W = $clog2(VLEN/8) + 1
) (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      valid_i,
    input  op_pkg::vop_e              op_i,
    input  vec_pkg::sew_e             sew_i,
    input  logic [vec_pkg::TAG_W-1:0] tag_i,
    input  logic                      scalar_i,
    input  logic [VLEN-1:0]           vs1_i,
    input  logic [VLEN-1:0]           vs2_i,
    input  logic [63:0]               rs1_i,
    input  logic [VLEN-1:0]           old_vd_i,
    input  logic [VLEN/8-1:0]         vm_i,
    input  logic                      use_mask_i,
    input  logic [VL_W-1:0]           vl_i,
    output logic                      vd_valid_o,
    output logic [VLEN-1:0]           vd_o,
    output logic                      rd_valid_o,
    output logic [63:0]               rd_o,
    output logic [vec_pkg::TAG_W-1:0] tag_o
);

    logic [VLEN-1:0]           op_a;
    logic                      alu_valid;
    logic [VLEN-1:0]           alu_vd;
    logic                      alu_rd_valid;
    logic [63:0]               alu_rd;
    logic                      mul_valid;
    logic [VLEN-1:0]           mul_vd;
    logic [vec_pkg::TAG_W-1:0] mul_tag;
    vec_pkg::sew_e             mul_sew;
    logic [VLEN-1:0]           mul_old_vd;
    logic [VLEN/8-1:0]         mul_vm;
    logic                      mul_use_mask;
    logic [VL_W-1:0]           mul_vl;

    operand_bcast #(.VLEN(VLEN)) operand_bcast_i (
        .sew_i    (sew_i),
        .scalar_i (scalar_i),
        .rs1_i    (rs1_i),
        .vs1_i    (vs1_i),
        .op_a_o   (op_a)
    );

    lane_alu #(.VLEN(VLEN)) lane_alu_i (
        .valid_i        (valid_i),
        .op_i           (op_i),
        .sew_i          (sew_i),
        .op_a_i         (op_a),
        .vs2_i          (vs2_i),
        .alu_valid_o    (alu_valid),
        .alu_vd_o       (alu_vd),
        .alu_rd_valid_o (alu_rd_valid),
        .alu_rd_o       (alu_rd)
    );

    mul_pipe #(.VLEN(VLEN)) mul_pipe_i (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .valid_i        (valid_i),
        .op_i           (op_i),
        .sew_i          (sew_i),
        .tag_i          (tag_i),
        .op_a_i         (op_a),
        .vs2_i          (vs2_i),
        .old_vd_i       (old_vd_i),
        .vm_i           (vm_i),
        .use_mask_i     (use_mask_i),
        .vl_i           (vl_i),
        .mul_valid_o    (mul_valid),
        .mul_vd_o       (mul_vd),
        .mul_tag_o      (mul_tag),
        .mul_sew_o      (mul_sew),
        .mul_old_vd_o   (mul_old_vd),
        .mul_vm_o       (mul_vm),
        .mul_use_mask_o (mul_use_mask),
        .mul_vl_o       (mul_vl)
    );

    result_stage #(.VLEN(VLEN)) result_stage_i (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .alu_valid_i    (alu_valid),
        .alu_vd_i       (alu_vd),
        .alu_rd_valid_i (alu_rd_valid),
        .alu_rd_i       (alu_rd),
        .mul_valid_i    (mul_valid),
        .mul_vd_i       (mul_vd),
        .mul_tag_i      (mul_tag),
        .mul_sew_i      (mul_sew),
        .mul_old_vd_i   (mul_old_vd),
        .mul_vm_i       (mul_vm),
        .mul_use_mask_i (mul_use_mask),
        .mul_vl_i       (mul_vl),
        .tag_i          (tag_i),
        .sew_i          (sew_i),
        .old_vd_i       (old_vd_i),
        .vm_i           (vm_i),
        .use_mask_i     (use_mask_i),
        .vl_i           (vl_i),
        .vd_valid_o     (vd_valid_o),
        .vd_o           (vd_o),
        .rd_valid_o     (rd_valid_o),
        .rd_o           (rd_o),
        .tag_o          (tag_o)
    );

endmodule

`default_nettype wire

// ==== verification/tb_clkgen.sv ====
// Testbench clock and reset generator
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD/2) clk_o = ~clk_o;
    end

    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rstn_o = 1'b1;   // Release just after the edge
    end

endmodule

`default_nettype wire

// ==== verification/simd_exec_unit_assert.sv ====
// Concurrent checks on result_stage completion and output strobes, with bind
`timescale 1ns/100ps
`default_nettype none

module simd_exec_unit_assert (
    input logic clk_i,
    input logic rstn_i,
    input logic alu_valid_i,
    input logic mul_valid_i,
    input logic vd_valid_i,
    input logic rd_valid_i
);

    // Issuer must keep completions apart
    a_one_path: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(alu_valid_i && mul_valid_i))
        else $error("ALU and multiply results complete in the same cycle");

    a_one_strobe: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(vd_valid_i && rd_valid_i))
        else $error("vd_valid_o and rd_valid_o high together");

    a_idle_in_reset: assert property (@(posedge clk_i)
        !rstn_i |-> (!vd_valid_i && !rd_valid_i))
        else $error("result strobe high during reset");

endmodule

bind result_stage simd_exec_unit_assert simd_exec_unit_assert_i (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .alu_valid_i (alu_valid_i),
    .mul_valid_i (mul_valid_i),
    .vd_valid_i  (vd_valid_o),
    .rd_valid_i  (rd_valid_o)
);

`default_nettype wire

// ==== verification/tb_simd_exec_unit.sv ====
// Testbench for simd_exec_unit: random issue, reference model, result checks, watchdog
`timescale 1ns/100ps
`default_nettype none

module tb_simd_exec_unit;

    localparam int VLEN       = 128;
    localparam int VL_W       = $clog2(VLEN/8) + 1;
    localparam int CLK_PERIOD = 8;
    localparam int N_ISSUE    = 400;
    localparam int WATCHDOG_CYCLES = N_ISSUE * 2 + 20;

    logic                      clk;
    logic                      rstn;
    logic                      valid;
    op_pkg::vop_e              op;
    vec_pkg::sew_e             sew;
    logic [vec_pkg::TAG_W-1:0] tag;
    logic                      scalar;
    logic [VLEN-1:0]           vs1;
    logic [VLEN-1:0]           vs2;
    logic [63:0]               rs1;
    logic [VLEN-1:0]           old_vd;
    logic [VLEN/8-1:0]         vm;
    logic                      use_mask;
    logic [VL_W-1:0]           vl;
    logic                      vd_valid;
    logic [VLEN-1:0]           vd;
    logic                      rd_valid;
    logic [63:0]               rd;
    logic [vec_pkg::TAG_W-1:0] tag_out;

    // Expected results keyed by completion cycle, kind 1 is vd and 2 is rd
    int                        exp_kind [int];
    logic [VLEN-1:0]           exp_vd [int];
    logic [63:0]               exp_rd [int];
    logic [vec_pkg::TAG_W-1:0] exp_tag [int];

    logic [63:0] rng = 64'd91686;
    int cyc;
    int issued;
    int skips;
    int results;
    int value_errs;
    int pulse_errs;

    tb_clkgen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(2)) tb_clkgen_i (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    simd_exec_unit #(.VLEN(VLEN)) simd_exec_unit_i (
        .clk_i      (clk),
        .rstn_i     (rstn),
        .valid_i    (valid),
        .op_i       (op),
        .sew_i      (sew),
        .tag_i      (tag),
        .scalar_i   (scalar),
        .vs1_i      (vs1),
        .vs2_i      (vs2),
        .rs1_i      (rs1),
        .old_vd_i   (old_vd),
        .vm_i       (vm),
        .use_mask_i (use_mask),
        .vl_i       (vl),
        .vd_valid_o (vd_valid),
        .vd_o       (vd),
        .rd_valid_o (rd_valid),
        .rd_o       (rd),
        .tag_o      (tag_out)
    );

    function automatic logic [63:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 7);
        rng = rng ^ (rng << 17);
        return rng;
    endfunction

    function automatic logic [VLEN-1:0] rand_vec();
        logic [VLEN-1:0] v;
        for (int l = 0; l < VLEN/64; l++) begin
            v[l*64 +: 64] = next_rand();
        end
        return v;
    endfunction

    function automatic logic [63:0] width_mask(input int sb);
        return (sb == 64) ? '1 : (64'd1 << sb) - 64'd1;
    endfunction

    function automatic logic [63:0] elem(input logic [VLEN-1:0] v, input int i, input int sb);
        logic [VLEN-1:0] t;
        t = v >> (i*sb);
        return t[63:0] & width_mask(sb);
    endfunction

    function automatic int op_latency(input op_pkg::vop_e o, input vec_pkg::sew_e s);
        if (o == op_pkg::OP_MUL || o == op_pkg::OP_MULHU) begin
            return (s == vec_pkg::SEW_64) ? op_pkg::MUL_LAT_WIDE : op_pkg::MUL_LAT_NARROW;
        end
        return op_pkg::ALU_LAT;
    endfunction

    // Element i: tail gives ones, masked off gives old vd, else the op result
    function automatic logic [VLEN-1:0] model_vd(
        input op_pkg::vop_e o, input vec_pkg::sew_e s, input logic sc,
        input logic [63:0] x, input logic [VLEN-1:0] v1, input logic [VLEN-1:0] v2,
        input logic [VLEN-1:0] old, input logic [VLEN/8-1:0] mask, input logic masked,
        input int len);
        int sb;
        int n;
        logic [63:0] m;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        logic [127:0] prod;
        logic [VLEN-1:0] res;
        sb = 8 << int'(s);
        n = VLEN / sb;
        m = width_mask(sb);
        res = '0;
        for (int i = 0; i < n; i++) begin
            a = sc ? (x & m) : elem(v1, i, sb);
            b = elem(v2, i, sb);
            prod = {64'd0, a} * {64'd0, b};
            case (o)
                op_pkg::OP_ADD: r = b + a;
                op_pkg::OP_SUB: r = b - a;
                op_pkg::OP_AND: r = b & a;
                op_pkg::OP_OR:  r = b | a;
                op_pkg::OP_XOR: r = b ^ a;
                op_pkg::OP_MUL: r = prod[63:0];
                default:        r = 64'(prod >> sb);     // High half
            endcase
            if (i >= len) r = m;
            else if (masked && !mask[i]) r = elem(old, i, sb);
            res = res | (VLEN'(r & m) << (i*sb));
        end
        return res;
    endfunction

    function automatic logic [63:0] model_rd(input vec_pkg::sew_e s, input logic [VLEN-1:0] v2);
        int sb;
        logic [63:0] e;
        sb = 8 << int'(s);
        e = elem(v2, 0, sb);
        if (e[sb-1]) e = e | ~width_mask(sb);
        return e;
    endfunction

    task automatic check_vd(input logic [VLEN-1:0] got, input logic [VLEN-1:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("error at %0t: vd_o is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_rd(input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("error at %0t: rd_o is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_tag(input logic [vec_pkg::TAG_W-1:0] got,
                             input logic [vec_pkg::TAG_W-1:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("error at %0t: tag_o is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_outputs();
        int k;
        k = exp_kind.exists(cyc) ? exp_kind[cyc] : 0;
        if (vd_valid && rd_valid) begin
            pulse_errs++;
            $display("at %0t both result strobes pulsed in one cycle", $time);
        end
        if (k == 1) begin
            if (!vd_valid) begin
                pulse_errs++;
                $display("at %0t the vector result with tag %0d never arrived", $time,
                         exp_tag[cyc]);
            end else begin
                check_vd(vd, exp_vd[cyc]);
                check_tag(tag_out, exp_tag[cyc]);
            end
        end else if (vd_valid) begin
            pulse_errs++;
            $display("at %0t a vector result arrived that nobody issued", $time);
        end
        if (k == 2) begin
            if (!rd_valid) begin
                pulse_errs++;
                $display("at %0t the scalar result with tag %0d never arrived", $time,
                         exp_tag[cyc]);
            end else begin
                check_rd(rd, exp_rd[cyc]);
                check_tag(tag_out, exp_tag[cyc]);
            end
        end else if (rd_valid) begin
            pulse_errs++;
            $display("at %0t a scalar result arrived that nobody issued", $time);
        end
        if (k != 0) begin
            results++;
            exp_kind.delete(cyc);
        end
    endtask

    // New instruction on the DUT inputs, held with valid low until issued
    task automatic make_candidate();
        logic [63:0] r;
        r = next_rand();
        op = op_pkg::vop_e'({1'b0, r[2:0]});
        sew = vec_pkg::sew_e'(r[4:3]);
        scalar = r[5];
        use_mask = r[6];
        tag = r[11:7];
        case (r[14:12])
            3'd0:    vl = '0;
            3'd1:    vl = VL_W'(VLEN/8);
            default: vl = VL_W'(int'(r[31:16]) % (VLEN/8 + 1));
        endcase
        rs1 = next_rand();
        vs1 = rand_vec();
        vs2 = rand_vec();
        old_vd = rand_vec();
        vm = (VLEN/8)'(next_rand());
    endtask

    task automatic issue_candidate(input int done);
        valid = 1'b1;
        exp_tag[done] = tag;
        if (op == op_pkg::OP_MV_X_S) begin
            exp_kind[done] = 2;
            exp_rd[done] = model_rd(sew, vs2);
        end else begin
            exp_kind[done] = 1;
            exp_vd[done] = model_vd(op, sew, scalar, rs1, vs1, vs2, old_vd, vm, use_mask,
                                    int'(vl));
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles with %0d of %0d issued",
                 WATCHDOG_CYCLES, issued, N_ISSUE);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        logic have_cand;
        int done;
        valid = 1'b0;
        op = op_pkg::OP_ADD;
        sew = vec_pkg::SEW_8;
        tag = '0;
        scalar = 1'b0;
        vs1 = '0;
        vs2 = '0;
        rs1 = '0;
        old_vd = '0;
        vm = '0;
        use_mask = 1'b0;
        vl = '0;
        cyc = 0;
        issued = 0;
        skips = 0;
        results = 0;
        value_errs = 0;
        pulse_errs = 0;
        have_cand = 1'b0;
        @(posedge rstn);
        repeat (3) begin                    // Quiet cycles after reset
            @(posedge clk);
            #1;
            cyc++;
            check_outputs();
        end
        while (issued < N_ISSUE) begin
            @(posedge clk);
            #1;
            cyc++;
            check_outputs();
            valid = 1'b0;
            if (!have_cand) begin
                make_candidate();
                have_cand = 1'b1;
            end
            done = cyc + op_latency(op, sew);
            if (exp_kind.exists(done)) begin
                skips++;                    // Completion slot already taken
            end else begin
                issue_candidate(done);
                issued++;
                have_cand = 1'b0;
            end
        end
        repeat (6) begin
            @(posedge clk);
            #1;
            cyc++;
            check_outputs();
            valid = 1'b0;
        end
        $display("%0d issued, %0d skipped, %0d results checked, %0d value errors, %0d pulse errors",
                 issued, skips, results, value_errs, pulse_errs);
        if (value_errs == 0 && pulse_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/vec_pkg.sv
verilog/op_pkg.sv
verilog/operand_bcast.sv
verilog/lane_alu.sv
verilog/mul_pipe.sv
verilog/result_stage.sv
verilog/simd_exec_unit.sv
verification/tb_clkgen.sv
verification/simd_exec_unit_assert.sv
verification/tb_simd_exec_unit.sv

// ==== Makefile ====
# Verilator build and run for the SIMD execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_simd_exec_unit
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Done: errors found" $(LOG); then \
	    echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
